//--- hw/loader_consts.svh
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// main memory, 16K words
`define MM_ADDR_W 14
`define MM_DATA_W 32

// target memories, 1K words each
`define IM_ADDR_W 10
`define DM_ADDR_W 10
`define DM_DATA_W 16

// word count, needs to hold 1024
`define SIZE_W 11

`define CMD_DEPTH 2   // queue entries == initial host credits
`define MM_RD_LAT 2   // main-memory read latency in cycles

`endif

//--- hw/loader_pkg.sv
`include "loader_consts.svh"

package loader_pkg;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_CLEAR = 1'b1
  } load_op_e;

  typedef enum logic {
    TGT_IM = 1'b0,
    TGT_DM = 1'b1
  } target_e;

  // one host command, 37 bits
  typedef struct packed {
    load_op_e               op;
    target_e                target;
    logic [`MM_ADDR_W-1:0]  src_addr;
    logic [`IM_ADDR_W-1:0]  dst_addr;
    logic [`SIZE_W-1:0]     size;
  } load_cmd_t;

  typedef logic [`MM_DATA_W-1:0] im_word_t;
  typedef logic [`DM_DATA_W-1:0] dm_word_t;   // low half of a source word

  typedef struct packed {
    logic [`MM_ADDR_W-1:0] addr;
    logic [`MM_DATA_W-1:0] data;
  } mm_write_t;

  typedef struct packed {
    logic [`IM_ADDR_W-1:0] addr;
    logic [`MM_DATA_W-1:0] data;
  } tgt_write_t;

  typedef struct packed {
    target_e  target;
    load_op_e op;
  } done_t;

  // tag of a read in flight
  typedef struct packed {
    target_e               target;
    logic [`IM_ADDR_W-1:0] addr;
  } rd_tag_t;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_ISSUE,
    ENG_DRAIN
  } eng_state_e;

endpackage

//--- hw/load_cmd_decoder.sv
`timescale 1ns/1ps
`include "loader_consts.svh"

module load_cmd_decoder (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  loader_pkg::load_cmd_t cmd,
  input  logic                  job_ready,
  output logic                  job_valid,
  output loader_pkg::load_cmd_t job,
  output logic                  cmd_credit
);

  localparam int DEPTH = `CMD_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  loader_pkg::load_cmd_t queue [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  full;
  logic                  push;
  logic                  pop;

  // wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full       = (count == CNT_W'(DEPTH));
  assign push       = cmd_valid && !full;
  assign job_valid  = (count != '0);
  assign job        = queue[rd_ptr];   // head entry
  assign pop        = job_valid && job_ready;
  assign cmd_credit = pop;             // one credit back per pop

  always_ff @(posedge clock) begin
    if (push) begin
      queue[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // host sent without a credit
  a_credit_ok: assert property (@(posedge clock) disable iff (reset)
    cmd_valid |-> !full)
    else $error("load_cmd_decoder: command while queue full");

endmodule

//--- hw/copy_engine.sv
`timescale 1ns/1ps
`include "loader_consts.svh"

module copy_engine (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   job_valid,
  input  loader_pkg::load_cmd_t  job,
  input  logic [`MM_DATA_W-1:0]  rd_data,
  output logic                   job_ready,
  output logic                   rd_en,
  output logic [`MM_ADDR_W-1:0]  rd_addr,
  output logic                   im_wr_en,
  output logic                   dm_wr_en,
  output loader_pkg::tgt_write_t tgt_wr,
  output logic                   done_valid,
  output loader_pkg::done_t      done
);

  localparam int LAT     = `MM_RD_LAT;
  localparam int DRAIN_W = $clog2(LAT + 1);

  loader_pkg::eng_state_e state;
  loader_pkg::load_op_e   cur_op;
  loader_pkg::target_e    cur_tgt;
  logic [`MM_ADDR_W-1:0]  src_addr;
  logic [`IM_ADDR_W-1:0]  dst_addr;
  logic [`SIZE_W-1:0]     remaining;
  logic [DRAIN_W-1:0]     drain_cnt;
  logic                   accept;
  logic                   issuing;
  logic                   clearing;
  logic [LAT-1:0]         pipe_v;
  loader_pkg::rd_tag_t    pipe_tag [LAT];

  assign job_ready = (state == loader_pkg::ENG_IDLE);
  assign accept    = job_valid && job_ready;
  assign issuing   = (state == loader_pkg::ENG_ISSUE);
  assign rd_en     = issuing && (cur_op == loader_pkg::OP_LOAD);
  assign clearing  = issuing && (cur_op == loader_pkg::OP_CLEAR);
  assign rd_addr   = src_addr;

  assign done.target = cur_tgt;
  assign done.op     = cur_op;

  // clear writes straight from the counters and load from the tail of the pipe
  always_comb begin
    if (clearing) begin
      im_wr_en    = (cur_tgt == loader_pkg::TGT_IM);
      dm_wr_en    = (cur_tgt == loader_pkg::TGT_DM);
      tgt_wr.addr = dst_addr;
      tgt_wr.data = '0;
    end else begin
      im_wr_en    = pipe_v[LAT-1] && (pipe_tag[LAT-1].target == loader_pkg::TGT_IM);
      dm_wr_en    = pipe_v[LAT-1] && (pipe_tag[LAT-1].target == loader_pkg::TGT_DM);
      tgt_wr.addr = pipe_tag[LAT-1].addr;
      tgt_wr.data = rd_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= loader_pkg::ENG_IDLE;
      done_valid <= 1'b0;
    end else begin
      done_valid <= 1'b0;
      case (state)
        loader_pkg::ENG_IDLE: begin
          if (accept) begin
            if (job.size == '0) done_valid <= 1'b1;   // nothing to move
            else                state      <= loader_pkg::ENG_ISSUE;
          end
        end
        loader_pkg::ENG_ISSUE: begin
          if (remaining == `SIZE_W'(1)) begin
            if (cur_op == loader_pkg::OP_LOAD) begin
              state <= loader_pkg::ENG_DRAIN;   // reads still in flight
            end else begin
              state      <= loader_pkg::ENG_IDLE;
              done_valid <= 1'b1;
            end
          end
        end
        loader_pkg::ENG_DRAIN: begin
          if (drain_cnt == '0) begin
            state      <= loader_pkg::ENG_IDLE;
            done_valid <= 1'b1;
          end
        end
        default: state <= loader_pkg::ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      cur_op    <= job.op;
      cur_tgt   <= job.target;
      src_addr  <= job.src_addr;
      dst_addr  <= job.dst_addr;
      remaining <= job.size;
      drain_cnt <= DRAIN_W'(LAT - 1);
    end else if (issuing) begin
      src_addr  <= src_addr + 1'b1;   // wraps at 14 bits
      dst_addr  <= dst_addr + 1'b1;
      remaining <= remaining - 1'b1;
    end else if (state == loader_pkg::ENG_DRAIN) begin
      drain_cnt <= drain_cnt - 1'b1;
    end
  end

  // read tags aligned with main-memory latency
  always_ff @(posedge clock) begin
    pipe_tag[0].target <= cur_tgt;
    pipe_tag[0].addr   <= dst_addr;
    for (int i = 1; i < LAT; i++) begin
      pipe_tag[i] <= pipe_tag[i-1];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pipe_v <= '0;
    end else begin
      pipe_v[0] <= rd_en;
      for (int i = 1; i < LAT; i++) begin
        pipe_v[i] <= pipe_v[i-1];
      end
    end
  end

  // a load write must never meet a clear write
  a_one_target: assert property (@(posedge clock) disable iff (reset)
    !(clearing && pipe_v[LAT-1]))
    else $error("copy_engine: clear and load write in one cycle");

  // no new job while reads are issued or still in flight
  a_busy: assert property (@(posedge clock) disable iff (reset)
    (rd_en || (|pipe_v)) |-> !job_ready)
    else $error("copy_engine: ready while reads are in flight");

endmodule

//--- hw/main_mem.sv
`timescale 1ns/1ps
`include "loader_consts.svh"

module main_mem (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  host_wr_en,
  input  loader_pkg::mm_write_t host_wr,
  input  logic                  rd_en,
  input  logic [`MM_ADDR_W-1:0] rd_addr,
  output logic [`MM_DATA_W-1:0] rd_data
);

  localparam int WORDS = 1 << `MM_ADDR_W;

  logic [`MM_DATA_W-1:0] mem [WORDS];
  logic [`MM_ADDR_W-1:0] addr_q;
  logic                  en_q;

  // host fill only
  always_ff @(posedge clock) begin
    if (host_wr_en) begin
      mem[host_wr.addr] <= host_wr.data;
    end
  end

  // address stage
  always_ff @(posedge clock) begin
    if (rd_en) begin
      addr_q <= rd_addr;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      en_q <= 1'b0;
    end else begin
      en_q <= rd_en;
    end
  end

  // data stage, second cycle of latency
  always_ff @(posedge clock) begin
    if (en_q) begin
      rd_data <= mem[addr_q];
    end
  end

  // host must wait for done before touching main memory
  a_no_host_during_copy: assert property (@(posedge clock) disable iff (reset)
    host_wr_en |-> !rd_en)
    else $error("main_mem: host write during copy");

endmodule

//--- hw/target_mem.sv
`timescale 1ns/1ps
`include "loader_consts.svh"

module target_mem #(
  parameter type word_t  = loader_pkg::im_word_t,
  parameter int  DEPTH_W = `IM_ADDR_W
) (
  input  logic                   clock,
  input  logic                   wr_en,
  input  loader_pkg::tgt_write_t wr,
  input  logic                   rd_en,
  input  logic [DEPTH_W-1:0]     rd_addr,
  output word_t                  rd_data
);

  localparam int WORDS = 1 << DEPTH_W;

  word_t              mem [WORDS];
  logic [DEPTH_W-1:0] wr_addr;
  word_t              wr_word;

  assign wr_addr = DEPTH_W'(wr.addr);
  assign wr_word = word_t'(wr.data);   // DM keeps the low half

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // host readback, one cycle
  always_ff @(posedge clock) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- hw/mem_loader_top.sv
`timescale 1ns/1ps
`include "loader_consts.svh"

module mem_loader_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  loader_pkg::load_cmd_t cmd,
  input  logic                  host_wr_en,
  input  loader_pkg::mm_write_t host_wr,
  input  logic                  host_rd_en,
  input  loader_pkg::target_e   host_rd_target,
  input  logic [`IM_ADDR_W-1:0] host_rd_addr,
  output logic                  cmd_credit,
  output logic                  done_valid,
  output loader_pkg::done_t     done,
  output logic [`MM_DATA_W-1:0] host_rd_data
);

  logic                   job_valid;
  logic                   job_ready;
  loader_pkg::load_cmd_t  job;
  logic                   rd_en;
  logic [`MM_ADDR_W-1:0]  rd_addr;
  logic [`MM_DATA_W-1:0]  rd_data;
  logic                   im_wr_en;
  logic                   dm_wr_en;
  loader_pkg::tgt_write_t tgt_wr;
  loader_pkg::im_word_t   im_rd_data;
  loader_pkg::dm_word_t   dm_rd_data;
  loader_pkg::target_e    rd_sel_q;

  load_cmd_decoder u_decoder (
    .clock, .reset, .cmd_valid, .cmd, .job_ready,
    .job_valid, .job, .cmd_credit
  );

  copy_engine u_engine (
    .clock, .reset, .job_valid, .job, .rd_data,
    .job_ready, .rd_en, .rd_addr, .im_wr_en, .dm_wr_en, .tgt_wr,
    .done_valid, .done
  );

  main_mem u_main_mem (
    .clock, .reset, .host_wr_en, .host_wr, .rd_en, .rd_addr, .rd_data
  );

  target_mem #(.word_t(loader_pkg::im_word_t), .DEPTH_W(`IM_ADDR_W)) u_im (
    .clock, .wr_en(im_wr_en), .wr(tgt_wr),
    .rd_en(host_rd_en), .rd_addr(host_rd_addr), .rd_data(im_rd_data)
  );

  target_mem #(.word_t(loader_pkg::dm_word_t), .DEPTH_W(`DM_ADDR_W)) u_dm (
    .clock, .wr_en(dm_wr_en), .wr(tgt_wr),
    .rd_en(host_rd_en), .rd_addr(host_rd_addr), .rd_data(dm_rd_data)
  );

  // select follows the memories' read register
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_sel_q <= loader_pkg::TGT_IM;
    end else if (host_rd_en) begin
      rd_sel_q <= host_rd_target;
    end
  end

  assign host_rd_data = (rd_sel_q == loader_pkg::TGT_IM) ? im_rd_data
                                                         : `MM_DATA_W'(dm_rd_data);

endmodule

//--- tb/tb_mem_loader.sv
`timescale 1ns/1ps
`include "loader_consts.svh"

module tb_mem_loader;

  localparam int MM_WORDS  = 1 << `MM_ADDR_W;
  localparam int TGT_WORDS = 1 << `IM_ADDR_W;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  cmd_valid;
  loader_pkg::load_cmd_t cmd;
  logic                  host_wr_en;
  loader_pkg::mm_write_t host_wr;
  logic                  host_rd_en;
  loader_pkg::target_e   host_rd_target;
  logic [`IM_ADDR_W-1:0] host_rd_addr;
  logic                  cmd_credit;
  logic                  done_valid;
  loader_pkg::done_t     done;
  logic [`MM_DATA_W-1:0] host_rd_data;

  // mirrors of main memory, IM and DM
  logic [`MM_DATA_W-1:0] mm_mirror [MM_WORDS];
  logic [`MM_DATA_W-1:0] im_mirror [TGT_WORDS];
  logic [`DM_DATA_W-1:0] dm_mirror [TGT_WORDS];
  logic                  im_touched [TGT_WORDS];
  logic                  dm_touched [TGT_WORDS];

  logic [31:0]       lfsr = 32'd98236;
  int                credits = `CMD_DEPTH;   // host side credit counter
  int                credit_cnt = 0;
  int                done_cnt = 0;
  int                cyc = 0;
  int                credit_cyc = 0;
  int                done_cyc = 0;
  loader_pkg::done_t last_done;
  loader_pkg::done_t done_q [$];
  int                errors = 0;
  int                checks = 0;
  int                cmp_errors = 0;
  int                cmp_checks = 0;
  int                test_no = 0;
  int                tests_failed = 0;
  int                err_base = 0;

  // readback expectation lags the request by one cycle
  logic [`MM_DATA_W-1:0] rd_exp;
  logic                  chk_v = 1'b0;
  logic [`MM_DATA_W-1:0] chk_exp;
  logic [`IM_ADDR_W-1:0] chk_addr;
  loader_pkg::target_e   chk_tgt;

  mem_loader_top DUT (
    .clock, .reset, .cmd_valid, .cmd, .host_wr_en, .host_wr,
    .host_rd_en, .host_rd_target, .host_rd_addr,
    .cmd_credit, .done_valid, .done, .host_rd_data
  );

  always #50 clock = ~clock;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // reference model applying one command to the mirrors
  function automatic void apply_cmd(input loader_pkg::load_cmd_t c);
    logic [`MM_ADDR_W-1:0] s;
    logic [`IM_ADDR_W-1:0] d;
    logic [`MM_DATA_W-1:0] w;
    s = c.src_addr;
    d = c.dst_addr;
    for (int i = 0; i < int'(c.size); i++) begin
      w = (c.op == loader_pkg::OP_LOAD) ? mm_mirror[s] : '0;
      if (c.target == loader_pkg::TGT_IM) begin
        im_mirror[d]  = w;
        im_touched[d] = 1'b1;
      end else begin
        dm_mirror[d]  = w[`DM_DATA_W-1:0];
        dm_touched[d] = 1'b1;
      end
      s = s + 1'b1;   // wraps at 14 bits
      d = d + 1'b1;
    end
  endfunction

  function automatic logic [`MM_DATA_W-1:0] exp_word(input loader_pkg::target_e t,
                                                     input logic [`IM_ADDR_W-1:0] a);
    if (t == loader_pkg::TGT_IM) return im_mirror[a];
    return {{(`MM_DATA_W - `DM_DATA_W){1'b0}}, dm_mirror[a]};
  endfunction

  // cycles from job acceptance to the done pulse
  function automatic int cmd_latency(input loader_pkg::load_cmd_t c);
    if (c.size == '0) return 1;
    if (c.op == loader_pkg::OP_LOAD) return int'(c.size) + `MM_RD_LAT + 1;
    return int'(c.size) + 1;
  endfunction

  // host credit counter and tracking of done and credit pulses
  always @(posedge clock) begin
    cyc <= cyc + 1;
    if (reset) begin
      credits <= `CMD_DEPTH;
    end else begin
      credits <= credits - (cmd_valid ? 1 : 0) + (cmd_credit ? 1 : 0);
      if (cmd_credit) begin
        credit_cnt <= credit_cnt + 1;
        credit_cyc <= cyc;
      end
      if (done_valid) begin
        done_cnt  <= done_cnt + 1;
        done_cyc  <= cyc;
        last_done <= done;
        done_q.push_back(done);
      end
    end
  end

  always @(posedge clock) begin
    chk_v    <= host_rd_en;
    chk_exp  <= rd_exp;
    chk_addr <= host_rd_addr;
    chk_tgt  <= host_rd_target;
  end

  // readback data is stable at the falling edge
  always @(negedge clock) begin
    if (chk_v) begin
      cmp_checks = cmp_checks + 1;
      if (host_rd_data !== chk_exp) begin
        cmp_errors = cmp_errors + 1;
        $display("ERROR host_rd_data %s[0x%03h] got 0x%08h exp 0x%08h",
                 (chk_tgt == loader_pkg::TGT_IM) ? "im" : "dm", chk_addr, host_rd_data, chk_exp);
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors = errors + 1;
    $display("ERROR %s got 0x%0h exp 0x%0h", name, got, exp);
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    $display("sim failed");
    $finish;
  endtask

  task automatic send_cmd(input loader_pkg::load_cmd_t c);
    int t;
    t = 0;
    while (credits == 0) begin
      @(negedge clock);
      t++;
      if (t > 2000) timeout_fail("a command credit");
    end
    cmd_valid = 1'b1;
    cmd       = c;
    @(negedge clock);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_done(input int n);
    int t;
    t = 0;
    while (done_cnt < n) begin
      @(negedge clock);
      t++;
      if (t > 5000) timeout_fail("a done pulse");
    end
  endtask

  task automatic read_one(input loader_pkg::target_e t, input logic [`IM_ADDR_W-1:0] a);
    host_rd_en     = 1'b1;
    host_rd_target = t;
    host_rd_addr   = a;
    rd_exp         = exp_word(t, a);
    @(negedge clock);
  endtask

  task automatic finish_reads();
    host_rd_en = 1'b0;
    @(negedge clock);
  endtask

  task automatic read_range(input loader_pkg::target_e t, input logic [`IM_ADDR_W-1:0] start,
                            input int n);
    for (int i = 0; i < n; i++) read_one(t, `IM_ADDR_W'(int'(start) + i));
    finish_reads();
  endtask

  task automatic read_touched();
    for (int a = 0; a < TGT_WORDS; a++) begin
      if (im_touched[a]) read_one(loader_pkg::TGT_IM, `IM_ADDR_W'(a));
      if (dm_touched[a]) read_one(loader_pkg::TGT_DM, `IM_ADDR_W'(a));
    end
    finish_reads();
  endtask

  task automatic fill_mm();
    for (int a = 0; a < MM_WORDS; a++) begin
      host_wr_en   = 1'b1;
      host_wr.addr = `MM_ADDR_W'(a);
      host_wr.data = rand_bits(`MM_DATA_W);
      mm_mirror[a] = host_wr.data;
      @(negedge clock);
    end
    host_wr_en = 1'b0;
  endtask

  // single command with latency and done field checks
  task automatic run_one(input loader_pkg::load_cmd_t c);
    int n0;
    n0 = done_cnt;
    apply_cmd(c);
    send_cmd(c);
    wait_done(n0 + 1);
    checks = checks + 3;
    if (done_cyc - credit_cyc != cmd_latency(c))
      report_mismatch("done latency", 32'(done_cyc - credit_cyc), 32'(cmd_latency(c)));
    if (last_done.target !== c.target)
      report_mismatch("done.target", 32'(last_done.target), 32'(c.target));
    if (last_done.op !== c.op)
      report_mismatch("done.op", 32'(last_done.op), 32'(c.op));
  endtask

  task automatic end_test(input string name);
    int e;
    e = errors + cmp_errors - err_base;
    test_no++;
    if (e != 0) tests_failed++;
    $display("test %0d %s %s (%0d errors)", test_no, name, (e == 0) ? "ok" : "FAILED", e);
    err_base = errors + cmp_errors;
  endtask

  initial begin
    loader_pkg::load_cmd_t c;
    loader_pkg::load_cmd_t c2;
    logic [`IM_ADDR_W-1:0] blk;
    int                    n0;
    int                    k0;
    reset          = 1'b1;
    cmd_valid      = 1'b0;
    cmd            = '0;
    host_wr_en     = 1'b0;
    host_wr        = '0;
    host_rd_en     = 1'b0;
    host_rd_target = loader_pkg::TGT_IM;
    host_rd_addr   = '0;
    rd_exp         = '0;
    for (int a = 0; a < TGT_WORDS; a++) begin
      im_touched[a] = 1'b0;
      dm_touched[a] = 1'b0;
    end
    repeat (8) @(negedge clock);
    reset = 1'b0;

    // quiet after reset
    for (int i = 0; i < 20; i++) begin
      checks = checks + 2;
      if (done_valid !== 1'b0) report_mismatch("done_valid", 32'(done_valid), 32'h0);
      if (cmd_credit !== 1'b0) report_mismatch("cmd_credit", 32'(cmd_credit), 32'h0);
      @(negedge clock);
    end
    checks = checks + 1;
    if (credits != `CMD_DEPTH) report_mismatch("host credits", 32'(credits), `CMD_DEPTH);
    end_test("reset");

    fill_mm();
    c          = '0;
    c.op       = loader_pkg::OP_LOAD;
    c.target   = loader_pkg::TGT_IM;
    c.src_addr = `MM_ADDR_W'(rand_bits(`MM_ADDR_W));
    c.dst_addr = `IM_ADDR_W'(rand_bits(`IM_ADDR_W));
    c.size     = `SIZE_W'(64);
    blk        = c.dst_addr;
    run_one(c);
    read_range(loader_pkg::TGT_IM, blk, 64);
    end_test("load_im");

    c.target   = loader_pkg::TGT_DM;
    c.src_addr = `MM_ADDR_W'(14'h3fe8);   // crosses the top of main memory
    c.dst_addr = `IM_ADDR_W'(rand_bits(`IM_ADDR_W));
    c.size     = `SIZE_W'(48);
    run_one(c);
    read_range(loader_pkg::TGT_DM, c.dst_addr, 48);
    end_test("load_dm");

    c.op       = loader_pkg::OP_CLEAR;
    c.target   = loader_pkg::TGT_IM;
    c.dst_addr = blk + `IM_ADDR_W'(8);
    c.size     = `SIZE_W'(24);
    run_one(c);
    read_range(loader_pkg::TGT_IM, blk, 64);   // neighbours included
    end_test("clear");

    n0          = done_cnt;
    k0          = credit_cnt;
    c           = '0;
    c.op        = loader_pkg::OP_LOAD;
    c.src_addr  = `MM_ADDR_W'(rand_bits(`MM_ADDR_W));
    c.dst_addr  = `IM_ADDR_W'(rand_bits(`IM_ADDR_W));
    c.size      = `SIZE_W'(16);
    c2          = c;
    c2.target   = loader_pkg::TGT_DM;
    c2.src_addr = `MM_ADDR_W'(rand_bits(`MM_ADDR_W));
    apply_cmd(c);
    apply_cmd(c2);
    send_cmd(c);
    send_cmd(c2);
    wait_done(n0 + 2);
    checks = checks + 3;
    if (credit_cnt - k0 != 2) report_mismatch("cmd_credit pulses", 32'(credit_cnt - k0), 32'h2);
    if (done_q[n0].target !== loader_pkg::TGT_IM)
      report_mismatch("first done.target", 32'(done_q[n0].target), 32'(loader_pkg::TGT_IM));
    if (done_q[n0+1].target !== loader_pkg::TGT_DM)
      report_mismatch("second done.target", 32'(done_q[n0+1].target), 32'(loader_pkg::TGT_DM));
    read_range(loader_pkg::TGT_IM, c.dst_addr, 16);
    read_range(loader_pkg::TGT_DM, c2.dst_addr, 16);
    end_test("queueing");

    n0 = done_cnt;
    for (int i = 0; i < 10; i++) begin
      c.op       = loader_pkg::load_op_e'(1'(rand_bits(1)));
      c.target   = loader_pkg::target_e'(1'(rand_bits(1)));
      c.src_addr = `MM_ADDR_W'(rand_bits(`MM_ADDR_W));
      c.dst_addr = `IM_ADDR_W'(rand_bits(`IM_ADDR_W));
      c.size     = `SIZE_W'(rand_bits(5));   // 0 to 31 words
      apply_cmd(c);
      send_cmd(c);
    end
    wait_done(n0 + 10);
    read_touched();
    end_test("random_mix");

    $display("%0d tests, %0d failed, %0d checks, %0d errors", test_no, tests_failed,
             checks + cmp_checks, errors + cmp_errors);
    if (errors + cmp_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+hw
hw/loader_pkg.sv
hw/load_cmd_decoder.sv
hw/copy_engine.sv
hw/main_mem.sv
hw/target_mem.sv
hw/mem_loader_top.sv
tb/tb_mem_loader.sv

//--- run.sh
#!/bin/sh
# build and run the loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_loader -f sim.f || exit 1
out=$(./obj_dir/Vtb_mem_loader)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
